/* logic/glay_defs.svh */
// ------------------------------
// Widths and run constants shared by the compute unit
// Word reads only, so the address step is one word
// GLAY_RUN_CYCLES must stay above one
// ------------------------------
`ifndef GLAY_DEFS_SVH
`define GLAY_DEFS_SVH

// ------------------------------
// Memory bus widths
// ------------------------------
`define GLAY_ADDR_W 32
`define GLAY_DATA_W 32
// Bytes per word, sets the address stride
`define GLAY_WORD_BYTES 4

// ------------------------------
// Job description and run length
// ------------------------------
// Up to 255 words per configuration block
`define GLAY_COUNT_W 8
// Fixed length of the stand-in processing interval
`define GLAY_RUN_CYCLES 64

`endif

/* logic/glay_bus_pkg.sv */
// ------------------------------
// Memory-side types of the compute unit
// Wishbone classic, read-only, single beat
// No byte selects, no write path, no error or retry
// ------------------------------
`include "glay_defs.svh"

package glay_bus_pkg;

  // ------------------------------
  // Plain vectors
  // ------------------------------
  // Byte address, word aligned in practice
  typedef logic [`GLAY_ADDR_W-1:0] glay_addr_t;
  // One memory word
  typedef logic [`GLAY_DATA_W-1:0] glay_data_t;

  // ------------------------------
  // Wishbone groups
  // ------------------------------
  // Master side
  // cyc and stb move together here
  typedef struct packed {
    logic       cyc;
    logic       stb;
    glay_addr_t adr;
  } glay_wb_req_t;

  // Slave side
  // dat only meaningful in the ack cycle
  typedef struct packed {
    logic       ack;
    glay_data_t dat;
  } glay_wb_resp_t;

endpackage : glay_bus_pkg

/* logic/glay_ctrl_pkg.sv */
// ------------------------------
// Control-side types of the compute unit
// Host handshake follows the ap_ctrl_chain style
// Descriptor base taken from the bus package by scoped name
// Compile after glay_bus_pkg
// ------------------------------
`include "glay_defs.svh"

package glay_ctrl_pkg;

  // Number of words in a configuration block
  typedef logic [`GLAY_COUNT_W-1:0] glay_count_t;

  // ------------------------------
  // Host side groups
  // ------------------------------
  // Job descriptor, valid is a level held by the host
  typedef struct packed {
    logic                     valid;
    glay_bus_pkg::glay_addr_t base;
    glay_count_t              count;
  } glay_descriptor_t;

  typedef struct packed {
    logic ap_start;
    logic ap_continue;
  } glay_control_in_t;

  // glay_start mirrors the internal start pulse
  typedef struct packed {
    logic ap_ready;
    logic ap_idle;
    logic ap_done;
    logic glay_start;
  } glay_control_out_t;

  // ------------------------------
  // State machines
  // ------------------------------
  // Host handshake
  typedef enum logic [1:0] {
    GLAY_CTRL_IDLE,
    GLAY_CTRL_ACCEPT,
    GLAY_CTRL_BUSY,
    GLAY_CTRL_DONE
  } glay_ctrl_state_e;

  // Setup reader, FINISH is the bus gap after a non-final ack
  typedef enum logic [1:0] {
    GLAY_FETCH_IDLE,
    GLAY_FETCH_REQUEST,
    GLAY_FETCH_FINISH
  } glay_fetch_state_e;

endpackage : glay_ctrl_pkg

/* logic/glay_setup_fetch.sv */
// ------------------------------
// Setup reader, one classic read per word
// Words read from base upward in GLAY_WORD_BYTES steps
// Signature is the XOR of all acked words
// Count zero finishes without touching the bus
// A start pulse mid-job restarts the reader
// ------------------------------
`include "glay_defs.svh"

module glay_setup_fetch (
  input  logic                          ap_clk        ,
  input  logic                          control_areset,
  input  logic                          glay_start    ,
  input  glay_bus_pkg::glay_addr_t      job_base      ,
  input  glay_ctrl_pkg::glay_count_t    job_count     ,
  input  glay_bus_pkg::glay_wb_resp_t   wb_resp       ,
  output glay_bus_pkg::glay_wb_req_t    wb_req        ,
  output glay_bus_pkg::glay_data_t      signature     ,
  output logic                          setup_done
);

// ------------------------------
// Reader state
// ------------------------------
  glay_ctrl_pkg::glay_fetch_state_e state     ;
  glay_bus_pkg::glay_addr_t         read_addr ;
  glay_ctrl_pkg::glay_count_t       words_left;
  logic                             last_word ;

  // Current read is the final one of the block
  assign last_word = (words_left == glay_ctrl_pkg::glay_count_t'(1));

// ------------------------------
// Bus drive
// ------------------------------
  // Request held steady until ack
  assign wb_req.cyc = (state == glay_ctrl_pkg::GLAY_FETCH_REQUEST);
  assign wb_req.stb = (state == glay_ctrl_pkg::GLAY_FETCH_REQUEST);
  assign wb_req.adr = read_addr;

// ------------------------------
// Sequencing
// ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      state      <= glay_ctrl_pkg::GLAY_FETCH_IDLE;
      read_addr  <= '0;
      words_left <= '0;
      signature  <= '0;
      setup_done <= 1'b0;
    end else if (glay_start) begin
      // New job, fresh signature
      read_addr  <= job_base;
      words_left <= job_count;
      signature  <= '0;
      if (job_count == '0) begin
        // Nothing to read
        state      <= glay_ctrl_pkg::GLAY_FETCH_IDLE;
        setup_done <= 1'b1;
      end else begin
        state      <= glay_ctrl_pkg::GLAY_FETCH_REQUEST;
        setup_done <= 1'b0;
      end
    end else begin
      case (state)
        glay_ctrl_pkg::GLAY_FETCH_REQUEST: begin
          // Slave may stall here any number of cycles
          if (wb_resp.ack) begin
            signature  <= signature ^ wb_resp.dat;
            read_addr  <= read_addr + glay_bus_pkg::glay_addr_t'(`GLAY_WORD_BYTES);
            words_left <= words_left - glay_ctrl_pkg::glay_count_t'(1);
            if (last_word) begin
              state      <= glay_ctrl_pkg::GLAY_FETCH_IDLE;
              setup_done <= 1'b1;
            end else begin
              state <= glay_ctrl_pkg::GLAY_FETCH_FINISH;
            end
          end
        end
        // One idle bus cycle between reads
        glay_ctrl_pkg::GLAY_FETCH_FINISH: begin
          state <= glay_ctrl_pkg::GLAY_FETCH_REQUEST;
        end
        // Idle holds until the next start
        default: begin
          state <= glay_ctrl_pkg::GLAY_FETCH_IDLE;
        end
      endcase
    end
  end

endmodule : glay_setup_fetch

/* logic/glay_run_timer.sv */
// ------------------------------
// Run timer, stand-in for graph processing
// run_done high exactly GLAY_RUN_CYCLES cycles after start
// Held until the next start pulse
// ------------------------------
`include "glay_defs.svh"

module glay_run_timer (
  input  logic ap_clk        ,
  input  logic control_areset,
  input  logic glay_start    ,
  output logic run_done
);

  // Wide enough to hold the full run length
  localparam int unsigned TIMER_W = $clog2(`GLAY_RUN_CYCLES + 1);

  typedef logic [TIMER_W-1:0] glay_timer_t;

  logic        running    ;
  glay_timer_t cycle_count;

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      running     <= 1'b0;
      cycle_count <= '0;
      run_done    <= 1'b0;
    end else if (glay_start) begin
      // First cycle after the pulse counts as one
      running     <= 1'b1;
      cycle_count <= glay_timer_t'(1);
      run_done    <= 1'b0;
    end else if (running) begin
      cycle_count <= cycle_count + glay_timer_t'(1);
      // Flag set at the edge ending cycle RUN_CYCLES-1
      if (cycle_count == glay_timer_t'(`GLAY_RUN_CYCLES - 1)) begin
        running  <= 1'b0;
        run_done <= 1'b1;
      end
    end
  end

endmodule : glay_run_timer

/* logic/glay_kernel_control.sv */
// ------------------------------
// Host handshake for one job at a time
// Host inputs registered once before use
// ap_ready and glay_start pulse together for one cycle
// ap_done held until registered ap_continue
// Done flags ignored during the accept cycle
// ------------------------------
module glay_kernel_control (
  input  logic                             ap_clk        ,
  input  logic                             control_areset,
  input  glay_ctrl_pkg::glay_control_in_t  control_in    ,
  input  glay_ctrl_pkg::glay_descriptor_t  descriptor    ,
  input  logic                             setup_done    ,
  input  logic                             run_done      ,
  output glay_ctrl_pkg::glay_control_out_t control_out   ,
  output logic                             glay_start    ,
  output glay_bus_pkg::glay_addr_t         job_base      ,
  output glay_ctrl_pkg::glay_count_t       job_count
);

// ------------------------------
// Registered host inputs
// ------------------------------
  glay_ctrl_pkg::glay_control_in_t control_in_reg;
  glay_ctrl_pkg::glay_descriptor_t descriptor_reg;
  glay_ctrl_pkg::glay_ctrl_state_e state         ;
  logic                            accept        ;

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      control_in_reg <= '0;
    end else begin
      control_in_reg <= control_in;
    end
  end

  // Descriptor one cycle behind the host
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      descriptor_reg.valid <= 1'b0;
    end else begin
      descriptor_reg <= descriptor;
    end
  end

  // New job seen while idle
  assign accept = (state == glay_ctrl_pkg::GLAY_CTRL_IDLE)
                & control_in_reg.ap_start & descriptor_reg.valid;

// ------------------------------
// Handshake FSM
// ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      state <= glay_ctrl_pkg::GLAY_CTRL_IDLE;
    end else begin
      case (state)
        glay_ctrl_pkg::GLAY_CTRL_IDLE: begin
          if (accept) state <= glay_ctrl_pkg::GLAY_CTRL_ACCEPT;
        end
        // Single cycle with the start pulse out
        glay_ctrl_pkg::GLAY_CTRL_ACCEPT: begin
          state <= glay_ctrl_pkg::GLAY_CTRL_BUSY;
        end
        // Flags already cleared by the start pulse
        glay_ctrl_pkg::GLAY_CTRL_BUSY: begin
          if (setup_done && run_done) state <= glay_ctrl_pkg::GLAY_CTRL_DONE;
        end
        default: begin
          if (control_in_reg.ap_continue) state <= glay_ctrl_pkg::GLAY_CTRL_IDLE;
        end
      endcase
    end
  end

  // Job payload captured on acceptance
  always_ff @(posedge ap_clk) begin
    if (accept) begin
      job_base  <= descriptor_reg.base;
      job_count <= descriptor_reg.count;
    end
  end

// ------------------------------
// Outputs decoded from state
// ------------------------------
  assign glay_start             = (state == glay_ctrl_pkg::GLAY_CTRL_ACCEPT);
  assign control_out.ap_ready   = glay_start;
  assign control_out.glay_start = glay_start;
  assign control_out.ap_idle    = (state == glay_ctrl_pkg::GLAY_CTRL_IDLE);
  assign control_out.ap_done    = (state == glay_ctrl_pkg::GLAY_CTRL_DONE);

endmodule : glay_kernel_control

/* logic/glay_kernel_cu.sv */
// ------------------------------
// Compute unit top level
// Reader and timer start together and run side by side
// Wishbone master talks to memory directly, no cache
// One job in flight at a time
// ------------------------------
module glay_kernel_cu (
  input  logic                             ap_clk        ,
  input  logic                             control_areset,
  input  glay_ctrl_pkg::glay_control_in_t  control_in    ,
  output glay_ctrl_pkg::glay_control_out_t control_out   ,
  input  glay_ctrl_pkg::glay_descriptor_t  descriptor    ,
  input  glay_bus_pkg::glay_wb_resp_t      wb_resp       ,
  output glay_bus_pkg::glay_wb_req_t       wb_req        ,
  output glay_bus_pkg::glay_data_t         signature
);

// ------------------------------
// Internal links
// ------------------------------
  // One-cycle pulse to reader and timer
  logic                       glay_start;
  glay_bus_pkg::glay_addr_t   job_base  ;
  glay_ctrl_pkg::glay_count_t job_count ;
  // Completion levels back to control
  logic                       setup_done;
  logic                       run_done  ;

// ------------------------------
// Host handshake
// ------------------------------
  glay_kernel_control inst_glay_kernel_control (
    .ap_clk        (ap_clk        ),
    .control_areset(control_areset),
    .control_in    (control_in    ),
    .descriptor    (descriptor    ),
    .setup_done    (setup_done    ),
    .run_done      (run_done      ),
    .control_out   (control_out   ),
    .glay_start    (glay_start    ),
    .job_base      (job_base      ),
    .job_count     (job_count     )
  );

// ------------------------------
// Configuration read
// ------------------------------
  glay_setup_fetch inst_glay_setup_fetch (
    .ap_clk        (ap_clk        ),
    .control_areset(control_areset),
    .glay_start    (glay_start    ),
    .job_base      (job_base      ),
    .job_count     (job_count     ),
    .wb_resp       (wb_resp       ),
    .wb_req        (wb_req        ),
    .signature     (signature     ),
    .setup_done    (setup_done    )
  );

  // Processing stand-in
  glay_run_timer inst_glay_run_timer (
    .ap_clk        (ap_clk        ),
    .control_areset(control_areset),
    .glay_start    (glay_start    ),
    .run_done      (run_done      )
  );

endmodule : glay_kernel_cu

/* tb/glay_kernel_cu_props.sv */
// ------------------------------
// Handshake assertions, bound into the compute unit
// All rules are ignored while reset is high
// ------------------------------
`include "glay_defs.svh"

module glay_kernel_cu_props (
  input logic                             ap_clk        ,
  input logic                             control_areset,
  input glay_ctrl_pkg::glay_control_out_t control_out   ,
  input glay_bus_pkg::glay_wb_req_t       wb_req        ,
  input glay_bus_pkg::glay_wb_resp_t      wb_resp
);

  // Cycles since the last start pulse, saturates past the run length
  int unsigned since_start;

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      since_start <= `GLAY_RUN_CYCLES + 1;
    end else if (control_out.glay_start) begin
      since_start <= 1;
    end else if (since_start <= `GLAY_RUN_CYCLES) begin
      since_start <= since_start + 1;
    end
  end

  // ------------------------------
  // Wishbone classic master rules
  // ------------------------------
  stb_needs_cyc: assert property (@(posedge ap_clk) disable iff (control_areset)
    wb_req.stb |-> wb_req.cyc)
    else $error("stb high without cyc");

  // Request frozen until the slave acks
  adr_held: assert property (@(posedge ap_clk) disable iff (control_areset)
    (wb_req.stb && !wb_resp.ack) |=> (wb_req.stb && $stable(wb_req.adr)))
    else $error("request dropped or address moved before ack");

  // ------------------------------
  // Host handshake rules
  // ------------------------------
  ready_one_cycle: assert property (@(posedge ap_clk) disable iff (control_areset)
    control_out.ap_ready |=> !control_out.ap_ready)
    else $error("ap_ready held longer than one cycle");

  done_after_run: assert property (@(posedge ap_clk) disable iff (control_areset)
    (since_start <= `GLAY_RUN_CYCLES) |-> !control_out.ap_done)
    else $error("ap_done inside the run interval");

endmodule : glay_kernel_cu_props

bind glay_kernel_cu glay_kernel_cu_props inst_glay_kernel_cu_props (
  .ap_clk        (ap_clk        ),
  .control_areset(control_areset),
  .control_out   (control_out   ),
  .wb_req        (wb_req        ),
  .wb_resp       (wb_resp       )
);

/* tb/glay_kernel_cu_tb.sv */
// ------------------------------
// Testbench for the compute unit
// Sparse random memory acks each read after 0 to 5 wait cycles
// Expected signature is the XOR of the words at base + i * word step
// Inputs driven and outputs sampled on the falling edge
// ------------------------------
`include "glay_defs.svh"

module glay_kernel_cu_tb;

  localparam int unsigned WAIT_LIMIT = 2000;
  localparam int FLAG_READY = 0;
  localparam int FLAG_DONE  = 1;
  localparam int FLAG_IDLE  = 2;

  logic                             ap_clk = 1'b0;
  logic                             control_areset;
  glay_ctrl_pkg::glay_control_in_t  control_in;
  glay_ctrl_pkg::glay_control_out_t control_out;
  glay_ctrl_pkg::glay_descriptor_t  descriptor;
  glay_bus_pkg::glay_wb_resp_t      wb_resp;
  glay_bus_pkg::glay_wb_req_t       wb_req;
  glay_bus_pkg::glay_data_t         signature;

  // Memory contents made up on first touch
  glay_bus_pkg::glay_data_t mem [glay_bus_pkg::glay_addr_t];
  // Addresses in the order they were acked
  glay_bus_pkg::glay_addr_t addr_log [$];
  bit                       ack_pending;
  int unsigned              ack_wait;
  int unsigned              last_ack_cycle = 0;

  int unsigned cycle_no = 0;
  int unsigned ready_pulses = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  bit          timed_out = 1'b0;

  glay_kernel_cu UUT (
    .ap_clk        (ap_clk        ),
    .control_areset(control_areset),
    .control_in    (control_in    ),
    .control_out   (control_out   ),
    .descriptor    (descriptor    ),
    .wb_resp       (wb_resp       ),
    .wb_req        (wb_req        ),
    .signature     (signature     )
  );

  always #5 ap_clk = ~ap_clk;

  always @(posedge ap_clk) cycle_no <= cycle_no + 1;

  // ap_ready pulses seen by the host
  always @(negedge ap_clk) begin
    if (control_out.ap_ready) ready_pulses <= ready_pulses + 1;
  end

  function automatic glay_bus_pkg::glay_data_t mem_word(input glay_bus_pkg::glay_addr_t addr);
    if (!mem.exists(addr)) begin
      mem[addr] = glay_bus_pkg::glay_data_t'($urandom);
    end
    return mem[addr];
  endfunction

  // ------------------------------
  // Wishbone slave model
  // ------------------------------
  initial begin
    wb_resp = '0;
    ack_pending = 1'b0;
    ack_wait = 0;
    forever begin
      @(negedge ap_clk);
      if (wb_resp.ack) begin
        // Read ended at the last rising edge so dat goes to junk
        wb_resp.ack = 1'b0;
        wb_resp.dat = glay_bus_pkg::glay_data_t'($urandom);
      end else if (!control_areset && wb_req.cyc && wb_req.stb) begin
        if (!ack_pending) begin
          ack_pending = 1'b1;
          ack_wait = $urandom_range(5, 0);
        end
        if (ack_wait == 0) begin
          ack_pending = 1'b0;
          wb_resp.ack = 1'b1;
          wb_resp.dat = mem_word(wb_req.adr);
          addr_log.push_back(wb_req.adr);
          last_ack_cycle = cycle_no;
        end else begin
          ack_wait--;
        end
      end
    end
  end

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_data(input glay_bus_pkg::glay_data_t got,
                            input glay_bus_pkg::glay_data_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR @%0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input glay_bus_pkg::glay_addr_t got,
                            input glay_bus_pkg::glay_addr_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR @%0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_ctrl(input glay_ctrl_pkg::glay_control_out_t got,
                            input glay_ctrl_pkg::glay_control_out_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR @%0t: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input glay_ctrl_pkg::glay_count_t got,
                             input glay_ctrl_pkg::glay_count_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR @%0t: %s got %0d expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERROR @%0t: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // Expected control word with glay_start beside ap_ready
  function automatic glay_ctrl_pkg::glay_control_out_t ctrl_word(input logic ready,
                                                                 input logic idle,
                                                                 input logic done);
    glay_ctrl_pkg::glay_control_out_t word;
    word.ap_ready   = ready;
    word.ap_idle    = idle;
    word.ap_done    = done;
    word.glay_start = ready;
    return word;
  endfunction

  function automatic bit flag_high(input int sel);
    case (sel)
      FLAG_READY: return control_out.ap_ready;
      FLAG_DONE:  return control_out.ap_done;
      default:    return control_out.ap_idle;
    endcase
  endfunction

  // Polls on falling edges until the flag shows or the limit runs out
  task automatic wait_for_flag(input int sel, input string what);
    int unsigned waited;
    waited = 0;
    while (!timed_out && !flag_high(sel)) begin
      @(negedge ap_clk);
      waited++;
      if (waited > WAIT_LIMIT && !flag_high(sel)) begin
        $display("timeout: %s did not arrive within %0d cycles", what, WAIT_LIMIT);
        timed_out = 1'b1;
      end
    end
  endtask

  // ------------------------------
  // One job from start to continue
  // ------------------------------
  task automatic run_job(input glay_ctrl_pkg::glay_count_t count);
    glay_bus_pkg::glay_addr_t base;
    glay_bus_pkg::glay_data_t expected;
    int unsigned              start_cycle;
    int unsigned              done_cycle;
    int unsigned              ready_before;
    base = glay_bus_pkg::glay_addr_t'($urandom) & ~glay_bus_pkg::glay_addr_t'(`GLAY_WORD_BYTES - 1);
    expected = '0;
    for (int i = 0; i < int'(count); i++) begin
      expected ^= mem_word(base + glay_bus_pkg::glay_addr_t'(i * `GLAY_WORD_BYTES));
    end
    addr_log.delete();
    last_ack_cycle = 0;
    ready_before = ready_pulses;
    control_in.ap_start = 1'b1;
    descriptor.valid = 1'b1;
    descriptor.base = base;
    descriptor.count = count;
    wait_for_flag(FLAG_READY, "ap_ready");
    if (timed_out) return;
    start_cycle = cycle_no;
    check_ctrl(control_out, ctrl_word(1'b1, 1'b0, 1'b0), "control at accept");
    // Scrambled payload so the job must run from the latched copy
    control_in.ap_start = 1'b0;
    descriptor.valid = 1'b0;
    descriptor.base = glay_bus_pkg::glay_addr_t'($urandom);
    descriptor.count = glay_ctrl_pkg::glay_count_t'($urandom);
    @(negedge ap_clk);
    check_ctrl(control_out, ctrl_word(1'b0, 1'b0, 1'b0), "control while busy");
    check_data(signature, '0, "signature cleared at start");
    wait_for_flag(FLAG_DONE, "ap_done");
    if (timed_out) return;
    // Run flag lands RUN_CYCLES after start and ap_done follows it
    check_flag(cycle_no - start_cycle > `GLAY_RUN_CYCLES, 1'b1, "ap_done after run interval");
    // Setup flag follows the last ack by one cycle
    done_cycle = start_cycle + `GLAY_RUN_CYCLES + 1;
    if (last_ack_cycle + 2 > done_cycle) begin
      done_cycle = last_ack_cycle + 2;
    end
    check_flag(cycle_no == done_cycle, 1'b1, "ap_done one cycle after both finish flags");
    check_data(signature, expected, "signature at ap_done");
    check_count(glay_ctrl_pkg::glay_count_t'(addr_log.size()), count, "read count");
    foreach (addr_log[i]) begin
      check_addr(addr_log[i], base + glay_bus_pkg::glay_addr_t'(i * `GLAY_WORD_BYTES),
                 "read address");
    end
    // Host holds back ap_continue for a while
    repeat ($urandom_range(4, 1)) begin
      @(negedge ap_clk);
      check_ctrl(control_out, ctrl_word(1'b0, 1'b0, 1'b1), "control held at done");
    end
    control_in.ap_continue = 1'b1;
    wait_for_flag(FLAG_IDLE, "ap_idle");
    control_in.ap_continue = 1'b0;
    if (timed_out) return;
    check_ctrl(control_out, ctrl_word(1'b0, 1'b1, 1'b0), "control after continue");
    check_count(glay_ctrl_pkg::glay_count_t'(ready_pulses - ready_before),
                glay_ctrl_pkg::glay_count_t'(1), "ap_ready pulses per job");
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (timed_out || errors != errors_before) begin
      tests_failed++;
      $display("test %0d %s: FAIL", tests_run, name);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int                         errors_before;
    glay_ctrl_pkg::glay_count_t count;
    void'($urandom(32'hb114));
    control_areset = 1'b1;
    control_in = '0;
    descriptor = '0;
    repeat (10) @(negedge ap_clk);
    control_areset = 1'b0;
    @(negedge ap_clk);
    errors_before = errors;
    check_ctrl(control_out, ctrl_word(1'b0, 1'b1, 1'b0), "control after reset");
    check_flag(wb_req.cyc | wb_req.stb, 1'b0, "bus idle after reset");
    check_data(signature, '0, "signature after reset");
    finish_test("reset state", errors_before);
    // Empty job lands between data jobs so it must clear a live signature
    for (int j = 0; j < 9 && !timed_out; j++) begin
      errors_before = errors;
      if (j == 4) begin
        count = '0;
      end else begin
        count = glay_ctrl_pkg::glay_count_t'($urandom_range(20, 1));
      end
      run_job(count);
      finish_test($sformatf("job of %0d words", count), errors_before);
    end
    $display("summary: %0d tests, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule : glay_kernel_cu_tb

/* flist.f */
+incdir+logic
logic/glay_bus_pkg.sv
logic/glay_ctrl_pkg.sv
logic/glay_setup_fetch.sv
logic/glay_run_timer.sv
logic/glay_kernel_control.sv
logic/glay_kernel_cu.sv
tb/glay_kernel_cu_props.sv
tb/glay_kernel_cu_tb.sv

/* Makefile */
# Verilator build and run of the compute unit testbench
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := glay_kernel_cu_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Output is shown, then searched for the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
